//--- hdl/ddr3_pkg.sv
package ddr3_pkg;

  // host word address is {row, bank, col}, high to low
  localparam int ROW_BITS  = 13;
  localparam int BANK_BITS = 3;
  localparam int COL_BITS  = 7;
  localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;
  // bank and row together identify one open page
  localparam int PAGE_BITS = ROW_BITS + BANK_BITS;

  // BL8 bursts, so the low three column bits on the DDR side are zero
  localparam int BL_BITS  = 3;
  localparam int CA_BITS  = COL_BITS + BL_BITS;
  localparam int PAD_BITS = ROW_BITS - CA_BITS - 1;

  // DDR3 command codes as {ras_n, cas_n, we_n}
  localparam logic [2:0] CMD_MODE = 3'b000;
  localparam logic [2:0] CMD_REFR = 3'b001;
  localparam logic [2:0] CMD_PREC = 3'b010;
  localparam logic [2:0] CMD_ACTV = 3'b011;
  localparam logic [2:0] CMD_WRIT = 3'b100;
  localparam logic [2:0] CMD_READ = 3'b101;
  localparam logic [2:0] CMD_ZQCL = 3'b110;
  localparam logic [2:0] CMD_NOOP = 3'b111;

  // timing, in controller clock cycles
  localparam int T_RCD  = 3;
  localparam int T_RTP  = 4;
  localparam int T_RFC  = 8;
  localparam int T_REFI = 200;

  // counter widths, wide enough for the largest load value
  localparam int BUSY_BITS = 4;
  localparam int REFI_BITS = 8;

  // one-hot scheduler states
  localparam logic [4:0] ST_IDLE = 5'b10000;
  localparam logic [4:0] ST_READ = 5'b01000;
  localparam logic [4:0] ST_WRIT = 5'b00100;
  localparam logic [4:0] ST_ACTV = 5'b00010;
  localparam logic [4:0] ST_REFR = 5'b00001;

  // DDR address word, row view for ACTIVATE, column view for READ/WRITE
  typedef union packed {
    logic [ROW_BITS-1:0] row;
    struct packed {
      logic [PAD_BITS-1:0] pad;
      // A10, auto-precharge
      logic                ap;
      logic [CA_BITS-1:0]  column;
    } col;
  } ddr_adr_t;

endpackage

//--- hdl/wb_ddr3_bridge.sv
`timescale 1ns/1ps

module wb_ddr3_bridge
  import ddr3_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  // Wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [ADDR_BITS-1:0] wb_adr_i,
  // address tag, last transfer of a burst
  input  logic                 wb_tga_i,
  output logic                 wb_ack_o,
  // request towards the scheduler
  input  logic                 mem_wrack_i,
  input  logic                 mem_rdack_i,
  output logic                 mem_wrreq_o,
  output logic                 mem_rdreq_o,
  output logic                 mem_lst_o,
  output logic [ADDR_BITS-1:0] mem_adr_o
);

  logic                 stb_w;
  logic                 burst_open;
  logic [PAGE_BITS-1:0] burst_page;

  // a transfer is live while both cycle and strobe are up
  assign stb_w = wb_cyc_i & wb_stb_i;

  // level requests, held by the master until the ack
  assign mem_wrreq_o = stb_w & wb_we_i;
  assign mem_rdreq_o = stb_w & ~wb_we_i;
  assign mem_lst_o   = wb_tga_i;
  assign mem_adr_o   = wb_adr_i;

  // scheduler acks land on the bus in the same cycle
  assign wb_ack_o = mem_wrack_i | mem_rdack_i;

  // burst stays open from the first ack up to the ack of the tagged transfer
  always_ff @(posedge clock) begin
    if (reset) begin
      burst_open <= 1'b0;
    end else if (wb_ack_o) begin
      burst_open <= ~wb_tga_i;
    end
  end

  // page of the burst, taken from its first transfer
  always_ff @(posedge clock) begin
    if (wb_ack_o && !burst_open) begin
      burst_page <= wb_adr_i[ADDR_BITS-1:COL_BITS];
    end
  end

  // the scheduler only acks a transfer that is still being strobed
  ack_needs_stb : assert property (@(posedge clock) disable iff (reset)
    wb_ack_o |-> stb_w);

  // master must not switch bank or row in the middle of a burst
  burst_same_page : assert property (@(posedge clock) disable iff (reset)
    burst_open && stb_w |-> wb_adr_i[ADDR_BITS-1:COL_BITS] == burst_page);

endmodule

//--- hdl/ddr3_fsm.sv
`timescale 1ns/1ps

module ddr3_fsm
  import ddr3_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  // requests from the bridge, held until acked
  input  logic                 mem_wrreq_i,
  input  logic                 mem_rdreq_i,
  input  logic                 mem_lst_i,
  input  logic [ADDR_BITS-1:0] mem_adr_i,
  output logic                 mem_wrack_o,
  output logic                 mem_rdack_o,
  // data layer handshake
  input  logic                 ddl_rdy_i,
  input  logic                 ddl_ref_i,
  output logic                 ddl_req_o,
  output logic [2:0]           ddl_cmd_o,
  output logic [BANK_BITS-1:0] ddl_ba_o,
  output ddr_adr_t             ddl_adr_o
);

  logic [4:0]           state;
  logic                 req_q;
  logic [2:0]           cmd_q;
  logic [BANK_BITS-1:0] ba_q;
  ddr_adr_t             adr_q;
  // burst kind, high for reads
  logic                 rd_q;

  logic [ROW_BITS-1:0]  row_w;
  logic [BANK_BITS-1:0] bank_w;
  ddr_adr_t             act_w;
  ddr_adr_t             col_w;
  logic                 accept_w;
  logic                 col_req_w;
  logic                 col_st_w;

  // host address split, {row, bank, col}
  assign row_w  = mem_adr_i[ADDR_BITS-1 -: ROW_BITS];
  assign bank_w = mem_adr_i[COL_BITS +: BANK_BITS];

  // the two decodings of the DDR address word
  always_comb begin
    act_w            = '0;
    act_w.row        = row_w;
    col_w            = '0;
    // auto-precharge rides on the last transfer of the burst
    col_w.col.ap     = mem_lst_i;
    col_w.col.column = {mem_adr_i[COL_BITS-1:0], {BL_BITS{1'b0}}};
  end

  assign accept_w = req_q & ddl_rdy_i;
  assign col_st_w = (state == ST_READ) || (state == ST_WRIT);
  // next transfer of the burst, of the latched kind
  assign col_req_w = rd_q ? mem_rdreq_i : mem_wrreq_i;

  // a transfer is acked on the cycle its column command is taken
  assign mem_rdack_o = accept_w & (state == ST_READ);
  assign mem_wrack_o = accept_w & (state == ST_WRIT);

  assign ddl_req_o = req_q;
  assign ddl_cmd_o = cmd_q;
  assign ddl_ba_o  = ba_q;
  assign ddl_adr_o = adr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      // NOOP on the command port while in reset
      state <= ST_IDLE;
      req_q <= 1'b0;
      cmd_q <= CMD_NOOP;
    end else begin
      case (state)
        ST_IDLE: begin
          // refresh first, only between bursts
          if (ddl_ref_i) begin
            state <= ST_REFR;
            req_q <= 1'b1;
            cmd_q <= CMD_REFR;
          end else if (mem_rdreq_i || mem_wrreq_i) begin
            state <= ST_ACTV;
            req_q <= 1'b1;
            cmd_q <= CMD_ACTV;
          end
        end
        ST_ACTV: begin
          // first transfer is still held, so its column command follows at once
          if (ddl_rdy_i) begin
            state <= rd_q ? ST_READ : ST_WRIT;
            cmd_q <= rd_q ? CMD_READ : CMD_WRIT;
          end
        end
        ST_READ, ST_WRIT: begin
          if (req_q) begin
            if (ddl_rdy_i) begin
              req_q <= 1'b0;
              // row closes by itself after the auto-precharge column
              if (adr_q.col.ap) begin
                state <= ST_IDLE;
              end
            end
          end else if (col_req_w) begin
            // master delays are absorbed here with no request out
            req_q <= 1'b1;
          end
        end
        ST_REFR: begin
          if (req_q) begin
            if (ddl_rdy_i) begin
              req_q <= 1'b0;
            end
          end else if (!ddl_ref_i) begin
            // data layer drops the request once refresh busy is over
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
          req_q <= 1'b0;
          cmd_q <= CMD_NOOP;
        end
      endcase
    end
  end

  // bank, address and burst kind
  always_ff @(posedge clock) begin
    if (state == ST_IDLE) begin
      ba_q  <= bank_w;
      adr_q <= act_w;
      rd_q  <= mem_rdreq_i;
    end else if (state == ST_ACTV && ddl_rdy_i) begin
      adr_q <= col_w;
    end else if (col_st_w && !req_q && col_req_w) begin
      adr_q <= col_w;
    end
  end

  state_onehot : assert property (@(posedge clock) disable iff (reset)
    $onehot(state));

  // a command waiting on the data layer must not move
  hold_while_busy : assert property (@(posedge clock) disable iff (reset)
    ddl_req_o && !ddl_rdy_i |=> ddl_req_o && $stable(ddl_cmd_o) &&
      $stable(ddl_ba_o) && $stable(ddl_adr_o));

endmodule

//--- hdl/ddr3_ddl.sv
`timescale 1ns/1ps

module ddr3_ddl
  import ddr3_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  // command from the scheduler
  input  logic                 ddl_req_i,
  input  logic [2:0]           ddl_cmd_i,
  input  logic [BANK_BITS-1:0] ddl_ba_i,
  input  ddr_adr_t             ddl_adr_i,
  output logic                 ddl_rdy_o,
  output logic                 ddl_ref_o,
  // registered command stream
  output logic                 ddr_cmd_vld_o,
  output logic [2:0]           ddr_cmd_o,
  output logic [BANK_BITS-1:0] ddr_ba_o,
  output ddr_adr_t             ddr_adr_o
);

  logic [BUSY_BITS-1:0] busy_q;
  logic [BUSY_BITS-1:0] load_w;
  logic [REFI_BITS-1:0] refi_q;
  logic                 ref_q;
  // refresh taken, waiting for its busy time to run out
  logic                 ref_acc_q;
  logic                 accept_w;
  logic                 refi_end_w;
  logic                 ref_done_w;

  assign ddl_rdy_o = (busy_q == '0);
  assign ddl_ref_o = ref_q;
  assign accept_w  = ddl_req_i & ddl_rdy_o;

  // busy time that each command leaves behind
  always_comb begin
    case (ddl_cmd_i)
      CMD_ACTV: load_w = BUSY_BITS'(T_RCD);
      CMD_REFR: load_w = BUSY_BITS'(T_RFC);
      CMD_WRIT, CMD_READ: begin
        // only the auto-precharge column closes the row
        load_w = ddl_adr_i.col.ap ? BUSY_BITS'(T_RTP) : '0;
      end
      default: load_w = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
    end else if (accept_w) begin
      busy_q <= load_w;
    end else if (!ddl_rdy_o) begin
      busy_q <= busy_q - BUSY_BITS'(1);
    end
  end

  assign refi_end_w = (refi_q == '0);
  // last busy cycle of a refresh
  assign ref_done_w = ref_acc_q && (busy_q == BUSY_BITS'(1));

  // free running refresh interval, request held until refresh is done
  always_ff @(posedge clock) begin
    if (reset) begin
      refi_q    <= REFI_BITS'(T_REFI - 1);
      ref_q     <= 1'b0;
      ref_acc_q <= 1'b0;
    end else begin
      if (refi_end_w) begin
        refi_q <= REFI_BITS'(T_REFI - 1);
      end else begin
        refi_q <= refi_q - REFI_BITS'(1);
      end
      if (accept_w && ddl_cmd_i == CMD_REFR) begin
        ref_acc_q <= 1'b1;
      end else if (ref_done_w) begin
        ref_acc_q <= 1'b0;
      end
      if (refi_end_w) begin
        ref_q <= 1'b1;
      end else if (ref_done_w) begin
        ref_q <= 1'b0;
      end
    end
  end

  // command valid and code, NOOP when nothing is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      ddr_cmd_vld_o <= 1'b0;
      ddr_cmd_o     <= CMD_NOOP;
    end else begin
      ddr_cmd_vld_o <= accept_w;
      ddr_cmd_o     <= accept_w ? ddl_cmd_i : CMD_NOOP;
    end
  end

  always_ff @(posedge clock) begin
    if (accept_w) begin
      ddr_ba_o  <= ddl_ba_i;
      ddr_adr_o <= ddl_adr_i;
    end
  end

  // no command lands on the bus inside a busy window
  actv_gap : assert property (@(posedge clock) disable iff (reset)
    ddr_cmd_vld_o && ddr_cmd_o == CMD_ACTV |=> !ddr_cmd_vld_o [*T_RCD]);

  refr_gap : assert property (@(posedge clock) disable iff (reset)
    ddr_cmd_vld_o && ddr_cmd_o == CMD_REFR |=> !ddr_cmd_vld_o [*T_RFC]);

endmodule

//--- hdl/ddr3_ctrl_top.sv
`timescale 1ns/1ps

module ddr3_ctrl_top
  import ddr3_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  // Wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [ADDR_BITS-1:0] wb_adr_i,
  input  logic                 wb_tga_i,
  output logic                 wb_ack_o,
  // DDR3 command stream
  output logic                 ddr_cmd_vld_o,
  output logic [2:0]           ddr_cmd_o,
  output logic [BANK_BITS-1:0] ddr_ba_o,
  output ddr_adr_t             ddr_adr_o
);

  // bridge to scheduler
  logic                 mem_wrreq;
  logic                 mem_rdreq;
  logic                 mem_lst;
  logic [ADDR_BITS-1:0] mem_adr;
  logic                 mem_wrack;
  logic                 mem_rdack;

  // scheduler to data layer
  logic                 ddl_req;
  logic [2:0]           ddl_cmd;
  logic [BANK_BITS-1:0] ddl_ba;
  ddr_adr_t             ddl_adr;
  logic                 ddl_rdy;
  logic                 ddl_ref;

  wb_ddr3_bridge u_bridge (
    .clock       (clock),
    .reset       (reset),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_tga_i    (wb_tga_i),
    .wb_ack_o    (wb_ack_o),
    .mem_wrack_i (mem_wrack),
    .mem_rdack_i (mem_rdack),
    .mem_wrreq_o (mem_wrreq),
    .mem_rdreq_o (mem_rdreq),
    .mem_lst_o   (mem_lst),
    .mem_adr_o   (mem_adr)
  );

  ddr3_fsm u_fsm (
    .clock       (clock),
    .reset       (reset),
    .mem_wrreq_i (mem_wrreq),
    .mem_rdreq_i (mem_rdreq),
    .mem_lst_i   (mem_lst),
    .mem_adr_i   (mem_adr),
    .mem_wrack_o (mem_wrack),
    .mem_rdack_o (mem_rdack),
    .ddl_rdy_i   (ddl_rdy),
    .ddl_ref_i   (ddl_ref),
    .ddl_req_o   (ddl_req),
    .ddl_cmd_o   (ddl_cmd),
    .ddl_ba_o    (ddl_ba),
    .ddl_adr_o   (ddl_adr)
  );

  ddr3_ddl u_ddl (
    .clock         (clock),
    .reset         (reset),
    .ddl_req_i     (ddl_req),
    .ddl_cmd_i     (ddl_cmd),
    .ddl_ba_i      (ddl_ba),
    .ddl_adr_i     (ddl_adr),
    .ddl_rdy_o     (ddl_rdy),
    .ddl_ref_o     (ddl_ref),
    .ddr_cmd_vld_o (ddr_cmd_vld_o),
    .ddr_cmd_o     (ddr_cmd_o),
    .ddr_ba_o      (ddr_ba_o),
    .ddr_adr_o     (ddr_adr_o)
  );

endmodule

//--- test/ddr3_ctrl_tb.sv
`timescale 1ns/1ps

module ddr3_ctrl_tb
  import ddr3_pkg::*;
();

  localparam int CLK_NS    = 20;
  localparam int RST_CYC   = 8;
  localparam int N_FIX     = 8;
  localparam int N_RAND    = 6;
  localparam int N_BURST   = N_FIX + N_RAND;
  // longest time one burst can hold off a pending refresh
  localparam int BURST_MAX = 60;
  localparam int IDLE_CYC  = T_REFI + BURST_MAX;
  localparam int ACK_WAIT  = 40;

  logic                 clock;
  logic                 reset;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [ADDR_BITS-1:0] wb_adr_i;
  logic                 wb_tga_i;
  logic                 wb_ack_o;
  logic                 ddr_cmd_vld_o;
  logic [2:0]           ddr_cmd_o;
  logic [BANK_BITS-1:0] ddr_ba_o;
  ddr_adr_t             ddr_adr_o;

  // burst table, one row per burst
  logic                 t_rd   [N_BURST];
  logic [BANK_BITS-1:0] t_bank [N_BURST];
  logic [ROW_BITS-1:0]  t_row  [N_BURST];
  logic [COL_BITS-1:0]  t_col  [N_BURST];
  int                   t_len  [N_BURST];
  // idle cycles the master inserts between transfers
  int                   t_gap  [N_BURST];
  logic                 table_ready = 1'b0;
  logic [31:0]          rng;

  // expected commands, oldest first
  logic [2:0]           exp_cmd_q [$];
  logic [BANK_BITS-1:0] exp_ba_q  [$];
  ddr_adr_t             exp_adr_q [$];
  logic                 exp_col_q [$];

  // monitor side
  int   cyc_cnt   = 0;
  int   ack_cnt   = 0;
  int   refr_cnt  = 0;
  int   last_refr = RST_CYC;
  int   last_act  = 0;
  int   last_ap   = 0;
  logic act_open  = 1'b0;
  logic ap_seen   = 1'b0;
  int   mon_mis   = 0;
  int   mon_oth   = 0;
  // driver side
  int   drv_mis   = 0;
  int   drv_oth   = 0;
  int   ack_mark  = 0;

  ddr3_ctrl_top u_dut (
    .clock         (clock),
    .reset         (reset),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_tga_i      (wb_tga_i),
    .wb_ack_o      (wb_ack_o),
    .ddr_cmd_vld_o (ddr_cmd_vld_o),
    .ddr_cmd_o     (ddr_cmd_o),
    .ddr_ba_o      (ddr_ba_o),
    .ddr_adr_o     (ddr_adr_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_NS / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_cmd(input string name, input logic [2:0] exp, input logic [2:0] act,
                           inout int errs);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      errs++;
    end
  endtask

  task automatic check_ba(input string name, input logic [BANK_BITS-1:0] exp,
                          input logic [BANK_BITS-1:0] act, inout int errs);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      errs++;
    end
  endtask

  // row view for ACTIVATE, column view for READ and WRITE
  task automatic check_adr(input ddr_adr_t exp, input ddr_adr_t act, input logic col_view,
                           inout int errs);
    if (!col_view && act.row !== exp.row) begin
      $display("mismatch at %0t: ddr_adr_o.row expected %h got %h", $time, exp.row, act.row);
      errs++;
    end
    if (col_view && act.col.ap !== exp.col.ap) begin
      $display("mismatch at %0t: ddr_adr_o.col.ap expected %b got %b", $time,
               exp.col.ap, act.col.ap);
      errs++;
    end
    if (col_view && {act.col.pad, act.col.column} !== {exp.col.pad, exp.col.column}) begin
      $display("mismatch at %0t: ddr_adr_o.col.column expected %h got %h", $time,
               exp.col.column, act.col.column);
      errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act,
                            inout int errs);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act, inout int errs);
    if (act != exp) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      errs++;
    end
  endtask

  task automatic set_burst(input int b, input logic rd, input logic [BANK_BITS-1:0] bank,
                           input logic [ROW_BITS-1:0] row, input logic [COL_BITS-1:0] col,
                           input int len, input int gap);
    t_rd[b]   = rd;
    t_bank[b] = bank;
    t_row[b]  = row;
    t_col[b]  = col;
    t_len[b]  = len;
    t_gap[b]  = gap;
  endtask

  task automatic build_table();
    int b;
    // kind (1 = read), bank, row, start column, length, gap
    set_burst(0, 1'b0, 3'd0, 13'h0010, 7'd0,   1, 0);
    set_burst(1, 1'b1, 3'd1, 13'h1abc, 7'd5,   4, 0);
    // last columns of a row, top bank and row
    set_burst(2, 1'b0, 3'd7, 13'h1fff, 7'd124, 4, 0);
    set_burst(3, 1'b1, 3'd3, 13'h0001, 7'd64,  2, 0);
    // master holds off between transfers
    set_burst(4, 1'b0, 3'd2, 13'h0555, 7'd10,  3, 5);
    set_burst(5, 1'b1, 3'd5, 13'h0aaa, 7'd100, 4, 3);
    set_burst(6, 1'b0, 3'd4, 13'h1234, 7'd127, 1, 0);
    set_burst(7, 1'b1, 3'd6, 13'h0000, 7'd0,   3, 0);
    rng = 32'd18;
    for (b = N_FIX; b < N_BURST; b++) begin
      rng       = xorshift(rng);
      t_rd[b]   = rng[0];
      t_bank[b] = rng[BANK_BITS:1];
      t_len[b]  = 1 + int'(rng[5:4]);
      t_gap[b]  = (rng[8:6] == 3'd7) ? 3 : 0;
      rng       = xorshift(rng);
      t_row[b]  = rng[ROW_BITS-1:0];
      // start low enough that four columns stay inside the row
      t_col[b]  = COL_BITS'(rng[31:16] % 16'd124);
    end
    table_ready = 1'b1;
  endtask

  // one ACTIVATE, then one column command per transfer
  task automatic expect_burst(input int b);
    ddr_adr_t            a;
    int                  k;
    logic [COL_BITS-1:0] col;
    a     = '0;
    a.row = t_row[b];
    exp_cmd_q.push_back(CMD_ACTV);
    exp_ba_q.push_back(t_bank[b]);
    exp_adr_q.push_back(a);
    exp_col_q.push_back(1'b0);
    for (k = 0; k < t_len[b]; k++) begin
      col          = t_col[b] + COL_BITS'(k);
      a            = '0;
      a.col.ap     = (k == t_len[b] - 1);
      // BL8, burst column moves up by three
      a.col.column = {col, {BL_BITS{1'b0}}};
      exp_cmd_q.push_back(t_rd[b] ? CMD_READ : CMD_WRIT);
      exp_ba_q.push_back(t_bank[b]);
      exp_adr_q.push_back(a);
      exp_col_q.push_back(1'b1);
    end
  endtask

  task automatic run_burst(input int b);
    int                  k;
    int                  w;
    logic [COL_BITS-1:0] col;
    expect_burst(b);
    for (k = 0; k < t_len[b]; k++) begin
      col      = t_col[b] + COL_BITS'(k);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = ~t_rd[b];
      wb_adr_i = {t_row[b], t_bank[b], col};
      wb_tga_i = (k == t_len[b] - 1);
      w = 0;
      do begin
        @(negedge clock);
        w++;
      end while (!wb_ack_o && w < ACK_WAIT);
      if (!wb_ack_o) begin
        $display("error at %0t: no acknowledge for burst %0d transfer %0d", $time, b, k);
        drv_oth++;
        wb_stb_i = 1'b0;
        break;
      end
      // transfer is taken on this rising edge
      @(posedge clock);
      if (k == t_len[b] - 1) begin
        check_count("wb_ack_o count", t_len[b], ack_cnt - ack_mark, drv_mis);
        ack_mark = ack_cnt;
      end
      @(negedge clock);
      if (t_gap[b] > 0 && k < t_len[b] - 1) begin
        wb_stb_i = 1'b0;
        repeat (t_gap[b]) begin
          @(negedge clock);
          if (ddr_cmd_vld_o) begin
            $display("error at %0t: command issued while burst %0d waited for the master",
                     $time, b);
            drv_oth++;
          end
        end
      end
    end
  endtask

  // compares one issued command and its spacing
  task automatic check_issued();
    logic [2:0]           e_cmd;
    logic [BANK_BITS-1:0] e_ba;
    ddr_adr_t             e_adr;
    logic                 e_col;
    if (refr_cnt > 0 && cyc_cnt - last_refr <= T_RFC) begin
      $display("error at %0t: command issued %0d cycles after refresh", $time,
               cyc_cnt - last_refr);
      mon_oth++;
    end
    if (ddr_cmd_o == CMD_REFR) begin
      if (cyc_cnt - last_refr > T_REFI + BURST_MAX) begin
        $display("error at %0t: refresh came %0d cycles after the previous one", $time,
                 cyc_cnt - last_refr);
        mon_oth++;
      end
      refr_cnt++;
      last_refr = cyc_cnt;
    end else if (exp_cmd_q.size() == 0) begin
      $display("error at %0t: command %b issued while none was expected", $time, ddr_cmd_o);
      mon_oth++;
    end else begin
      e_cmd = exp_cmd_q.pop_front();
      e_ba  = exp_ba_q.pop_front();
      e_adr = exp_adr_q.pop_front();
      e_col = exp_col_q.pop_front();
      check_cmd("ddr_cmd_o", e_cmd, ddr_cmd_o, mon_mis);
      check_ba("ddr_ba_o", e_ba, ddr_ba_o, mon_mis);
      check_adr(e_adr, ddr_adr_o, e_col, mon_mis);
      if (!e_col) begin
        if (ap_seen && cyc_cnt - last_ap < T_RTP) begin
          $display("error at %0t: activate too soon after auto-precharge", $time);
          mon_oth++;
        end
        last_act = cyc_cnt;
        act_open = 1'b1;
      end else begin
        if (act_open && cyc_cnt - last_act < T_RCD) begin
          $display("error at %0t: first column command too soon after activate", $time);
          mon_oth++;
        end
        act_open = 1'b0;
        if (ddr_adr_o.col.ap) begin
          last_ap = cyc_cnt;
          ap_seen = 1'b1;
        end
      end
    end
  endtask

  // outputs are registered, so they are sampled mid cycle
  always @(negedge clock) begin
    cyc_cnt = cyc_cnt + 1;
    if (!reset) begin
      if (wb_ack_o) begin
        ack_cnt = ack_cnt + 1;
      end
      if (ddr_cmd_vld_o) begin
        check_issued();
      end
    end
  end

  initial begin : watchdog
    int n_xfer;
    int b;
    wait (table_ready);
    n_xfer = 0;
    for (b = 0; b < N_BURST; b++) begin
      n_xfer += t_len[b];
    end
    #((n_xfer * 40 + 2 * T_REFI) * CLK_NS);
    $display("timeout: the run did not finish in time for %0d transfers", n_xfer);
    $display("sim failed");
    $finish;
  end

  initial begin : main
    int b;
    reset    = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_tga_i = 1'b0;
    build_table();
    repeat (RST_CYC) @(posedge clock);
    @(negedge clock);
    check_flag("ddr_cmd_vld_o", 1'b0, ddr_cmd_vld_o, drv_mis);
    check_flag("wb_ack_o", 1'b0, wb_ack_o, drv_mis);
    check_cmd("ddr_cmd_o", CMD_NOOP, ddr_cmd_o, drv_mis);
    reset = 1'b0;
    // nothing moves before the first request
    repeat (4) begin
      @(negedge clock);
      check_flag("ddr_cmd_vld_o", 1'b0, ddr_cmd_vld_o, drv_mis);
      check_flag("wb_ack_o", 1'b0, wb_ack_o, drv_mis);
    end
    for (b = 0; b < N_BURST; b++) begin
      run_burst(b);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_tga_i = 1'b0;
    // long idle gap, refresh has to keep coming
    repeat (IDLE_CYC) @(negedge clock);
    @(posedge clock);
    if (refr_cnt == 0) begin
      $display("error at %0t: no refresh was issued during the run", $time);
      drv_oth++;
    end else if (cyc_cnt - last_refr > T_REFI + BURST_MAX) begin
      $display("error at %0t: refresh missing for %0d cycles", $time, cyc_cnt - last_refr);
      drv_oth++;
    end
    if (exp_cmd_q.size() != 0) begin
      $display("error at %0t: %0d expected commands were never issued", $time,
               exp_cmd_q.size());
      drv_oth++;
    end
    $display("errors: %0d mismatches, %0d other failures, %0d refreshes seen",
             drv_mis + mon_mis, drv_oth + mon_oth, refr_cnt);
    if (drv_mis + mon_mis + drv_oth + mon_oth == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/ddr3_pkg.sv
hdl/wb_ddr3_bridge.sv
hdl/ddr3_fsm.sv
hdl/ddr3_ddl.sv
hdl/ddr3_ctrl_top.sv
test/ddr3_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# build the ddr3 controller testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f build.f --top-module ddr3_ctrl_tb --Mdir obj_dir -o ddr3_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ddr3_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
